/* rtl/rv_ctrl_pkg.sv */
package rv_ctrl_pkg;

    // vector types for words and instruction fields
    typedef logic [31:0] word_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  opcode5_t;
    typedef logic [2:0]  func3_t;

    // select codes handed to the datapath
    typedef logic [1:0]  pc_sel_t;
    typedef logic [1:0]  wb_sel_t;
    typedef logic [2:0]  mem_sel_t;

    localparam pc_sel_t PC_PLUS4 = 2'd0;
    localparam pc_sel_t PC_ALU   = 2'd1;
    localparam pc_sel_t PC_RESET = 2'd3;

    localparam wb_sel_t WB_MEM = 2'd0;
    localparam wb_sel_t WB_ALU = 2'd1;
    localparam wb_sel_t WB_PC4 = 2'd2;

    localparam mem_sel_t MEM_BIOS = 3'd0;
    localparam mem_sel_t MEM_DMEM = 3'd1;
    localparam mem_sel_t MEM_IO   = 3'd2;

    // opcode field, instruction bits 6:2
    localparam opcode5_t OPC_LUI_5       = 5'b01101;
    localparam opcode5_t OPC_AUIPC_5     = 5'b00101;
    localparam opcode5_t OPC_JAL_5       = 5'b11011;
    localparam opcode5_t OPC_JALR_5      = 5'b11001;
    localparam opcode5_t OPC_BRANCH_5    = 5'b11000;
    localparam opcode5_t OPC_LOAD_5      = 5'b00000;
    localparam opcode5_t OPC_STORE_5     = 5'b01000;
    localparam opcode5_t OPC_ARI_RTYPE_5 = 5'b01100;
    localparam opcode5_t OPC_ARI_ITYPE_5 = 5'b00100;
    localparam opcode5_t OPC_CSR_5       = 5'b11100;

    // branch conditions, instruction bits 14:12
    localparam func3_t FNC_BEQ  = 3'b000;
    localparam func3_t FNC_BNE  = 3'b001;
    localparam func3_t FNC_BLT  = 3'b100;
    localparam func3_t FNC_BGE  = 3'b101;
    localparam func3_t FNC_BLTU = 3'b110;
    localparam func3_t FNC_BGEU = 3'b111;

    // store here clears cycle and retired counts
    localparam word_t IO_CNT_RST_ADDR = 32'h8000_0018;

    // addi x0, x0, 0
    localparam instr_t NOP_INSTR = 32'h0000_0013;

endpackage

/* rtl/branch_comp.sv */
`timescale 1ns/1ps

module branch_comp import rv_ctrl_pkg::*; (
    input  word_t rs1_data,
    input  word_t rs2_data,
    input  logic  brun,
    output logic  breq,
    output logic  brlt
);

    logic lt_signed;
    logic lt_unsigned;

    // equality does not care about sign
    assign breq = (rs1_data == rs2_data);

    // both flavours of less-than, picked below
    assign lt_signed   = ($signed(rs1_data) < $signed(rs2_data));
    assign lt_unsigned = (rs1_data < rs2_data);

    // bltu / bgeu set brun
    always_comb begin
        if (brun) begin
            brlt = lt_unsigned;
        end else begin
            brlt = lt_signed;
        end
    end

endmodule

/* rtl/stage3_reg.sv */
`timescale 1ns/1ps

module stage3_reg import rv_ctrl_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  instr_t instruction_s2,
    input  word_t  alu_addr,
    input  logic   instr_valid_s2,
    output instr_t instruction_s3,
    output word_t  addr_s3,
    output logic   instr_valid_s3
);

    // control side, cleared on reset
    always_ff @(posedge clk) begin
        if (rst) begin
            instruction_s3 <= NOP_INSTR;
            instr_valid_s3 <= 1'b0;
        end else begin
            instr_valid_s3 <= instr_valid_s2;
            // bubble becomes a nop
            if (instr_valid_s2) begin
                instruction_s3 <= instruction_s2;
            end else begin
                instruction_s3 <= NOP_INSTR;
            end
        end
    end

    // alu address follows the instruction into stage 3
    always_ff @(posedge clk) begin
        addr_s3 <= alu_addr;
    end

    // stage 3 is empty right after reset
    a_empty_after_reset: assert property (
        @(posedge clk) rst |=> (!instr_valid_s3 && instruction_s3 == NOP_INSTR)
    ) else $error("stage 3 not empty after reset");

endmodule

/* rtl/s3_control.sv */
`timescale 1ns/1ps

module s3_control import rv_ctrl_pkg::*; (
    input  logic     rst,
    input  instr_t   instruction_s2,
    input  instr_t   instruction_s3,
    input  word_t    addr_s3,
    input  logic     instr_valid_s3,
    input  logic     breq,
    input  logic     brlt,
    input  logic     uart_rx_valid,
    input  logic     uart_tx_ready,
    input  logic [7:0] uart_rx_out,
    input  word_t    cyc_counter,
    input  word_t    instr_counter,
    output logic     brun,
    output pc_sel_t  pc_sel,
    output wb_sel_t  wb_sel,
    output logic     reg_we,
    output mem_sel_t mem_sel,
    output logic     cnt_clear,
    output word_t    io_value
);

    opcode5_t opcode5_s2;
    func3_t   func3_s2;
    opcode5_t opcode5_s3;
    logic     br_taken;
    word_t    uart_value;
    word_t    counter_num;

    assign opcode5_s2 = instruction_s2[6:2];
    assign func3_s2   = instruction_s2[14:12];
    assign opcode5_s3 = instruction_s3[6:2];

    // unsigned compare only for bltu / bgeu
    assign brun = (func3_s2 == FNC_BLTU) || (func3_s2 == FNC_BGEU);

    always_comb begin
        case (func3_s2)
            FNC_BEQ:  br_taken = breq;
            FNC_BNE:  br_taken = !breq;
            FNC_BLT:  br_taken = brlt;
            FNC_BGE:  br_taken = !brlt;
            FNC_BLTU: br_taken = brlt;
            FNC_BGEU: br_taken = !brlt;
            default:  br_taken = 1'b0;
        endcase
    end

    // next pc for the stage-2 instruction
    always_comb begin
        if (rst) begin
            pc_sel = PC_RESET;
        end else if (opcode5_s2 == OPC_JAL_5 || opcode5_s2 == OPC_JALR_5) begin
            pc_sel = PC_ALU;
        end else if (opcode5_s2 == OPC_BRANCH_5 && br_taken) begin
            pc_sel = PC_ALU;
        end else begin
            pc_sel = PC_PLUS4;
        end
    end

    // writeback decode
    // a bubble arrives here as a nop
    always_comb begin
        case (opcode5_s3)
            OPC_LUI_5, OPC_AUIPC_5, OPC_ARI_RTYPE_5, OPC_ARI_ITYPE_5: begin
                wb_sel = WB_ALU;
                reg_we = 1'b1;
            end
            OPC_JAL_5, OPC_JALR_5: begin
                wb_sel = WB_PC4;
                reg_we = 1'b1;
            end
            OPC_LOAD_5: begin
                wb_sel = WB_MEM;
                reg_we = 1'b1;
            end
            OPC_BRANCH_5, OPC_STORE_5: begin
                wb_sel = WB_MEM;
                reg_we = 1'b0;
            end
            default: begin
                // csr lands here too
                wb_sel = WB_ALU;
                reg_we = 1'b0;
            end
        endcase
    end

    // region from the top two address bits
    always_comb begin
        case (addr_s3[31:30])
            2'b00:   mem_sel = MEM_DMEM;
            2'b01:   mem_sel = MEM_BIOS;
            2'b10:   mem_sel = MEM_IO;
            default: mem_sel = MEM_DMEM;
        endcase
    end

    assign cnt_clear = instr_valid_s3 && (opcode5_s3 == OPC_STORE_5)
                       && (addr_s3 == IO_CNT_RST_ADDR);

    // memory-mapped reads
    assign uart_value  = addr_s3[2] ? {24'b0, uart_rx_out}
                                    : {30'b0, uart_rx_valid, uart_tx_ready};
    assign counter_num = addr_s3[2] ? instr_counter : cyc_counter;
    assign io_value    = (addr_s3[4] || addr_s3[5]) ? counter_num : uart_value;

    // reset redirect only while the core is held in reset
    always_comb begin
        if (!rst) begin
            assert (pc_sel != PC_RESET)
                else $error("pc_sel is PC_RESET outside of reset");
        end
    end

endmodule

/* rtl/perf_counters.sv */
`timescale 1ns/1ps

module perf_counters import rv_ctrl_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  instr_valid_s3,
    input  logic  cnt_clear,
    output word_t cyc_counter,
    output word_t instr_counter
);

    // clear wins over any increment
    always_ff @(posedge clk) begin
        if (rst || cnt_clear) begin
            cyc_counter <= '0;
        end else begin
            cyc_counter <= cyc_counter + 32'd1;
        end
    end

    // retired count, one per valid stage-3 instruction
    always_ff @(posedge clk) begin
        if (rst || cnt_clear) begin
            instr_counter <= '0;
        end else if (instr_valid_s3) begin
            instr_counter <= instr_counter + 32'd1;
        end
    end

    // at most one retire per cycle
    a_retire_bound: assert property (
        @(posedge clk) disable iff (rst) instr_counter <= cyc_counter
    ) else $error("instr_counter exceeds cyc_counter");

endmodule

/* rtl/ctrl_top.sv */
`timescale 1ns/1ps

module ctrl_top import rv_ctrl_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  instr_t   instruction_s2,
    input  logic     instr_valid_s2,
    input  word_t    rs1_data,
    input  word_t    rs2_data,
    input  word_t    alu_addr,
    input  logic     uart_rx_valid,
    input  logic     uart_tx_ready,
    input  logic [7:0] uart_rx_out,
    output pc_sel_t  pc_sel,
    output wb_sel_t  wb_sel,
    output logic     reg_we,
    output mem_sel_t mem_sel,
    output word_t    io_value
);

    logic   brun;
    logic   breq;
    logic   brlt;
    instr_t instruction_s3;
    word_t  addr_s3;
    logic   instr_valid_s3;
    logic   cnt_clear;
    word_t  cyc_counter;
    word_t  instr_counter;

    // stage-2 operand compare
    branch_comp i_branch_comp (
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .brun     (brun),
        .breq     (breq),
        .brlt     (brlt)
    );

    stage3_reg i_stage3_reg (
        .clk            (clk),
        .rst            (rst),
        .instruction_s2 (instruction_s2),
        .alu_addr       (alu_addr),
        .instr_valid_s2 (instr_valid_s2),
        .instruction_s3 (instruction_s3),
        .addr_s3        (addr_s3),
        .instr_valid_s3 (instr_valid_s3)
    );

    s3_control i_s3_control (
        .rst            (rst),
        .instruction_s2 (instruction_s2),
        .instruction_s3 (instruction_s3),
        .addr_s3        (addr_s3),
        .instr_valid_s3 (instr_valid_s3),
        .breq           (breq),
        .brlt           (brlt),
        .uart_rx_valid  (uart_rx_valid),
        .uart_tx_ready  (uart_tx_ready),
        .uart_rx_out    (uart_rx_out),
        .cyc_counter    (cyc_counter),
        .instr_counter  (instr_counter),
        .brun           (brun),
        .pc_sel         (pc_sel),
        .wb_sel         (wb_sel),
        .reg_we         (reg_we),
        .mem_sel        (mem_sel),
        .cnt_clear      (cnt_clear),
        .io_value       (io_value)
    );

    perf_counters i_perf_counters (
        .clk            (clk),
        .rst            (rst),
        .instr_valid_s3 (instr_valid_s3),
        .cnt_clear      (cnt_clear),
        .cyc_counter    (cyc_counter),
        .instr_counter  (instr_counter)
    );

endmodule

/* test/tb_ctrl_top.sv */
`timescale 1ns/1ps

module tb_ctrl_top import rv_ctrl_pkg::*; ();

    localparam int RESET_CYCLES   = 5;
    localparam int RANDOM_CYCLES  = 2000;
    localparam int RESUME_CYCLES  = 6;
    localparam int DRAIN_CYCLES   = 4;
    // reset, random and directed phases take about 2,030 cycles
    localparam int TIMEOUT_CYCLES = 3000;

    localparam word_t IO_BASE  = 32'h8000_0000;
    localparam word_t CYC_ADDR = 32'h8000_0010;
    localparam word_t RET_ADDR = 32'h8000_0014;
    // sw x0, 0(x0)
    localparam instr_t STORE_WORD = {17'd0, 3'b010, 5'd0, OPC_STORE_5, 2'b11};

    logic       clk;
    logic       rst;
    instr_t     instruction_s2;
    logic       instr_valid_s2;
    word_t      rs1_data;
    word_t      rs2_data;
    word_t      alu_addr;
    logic       uart_rx_valid;
    logic       uart_tx_ready;
    logic [7:0] uart_rx_out;
    pc_sel_t    pc_sel;
    wb_sel_t    wb_sel;
    logic       reg_we;
    mem_sel_t   mem_sel;
    word_t      io_value;

    integer seed = 32'h31c4_d970;
    int     cycle_count = 0;

    // stage-3 and counter model
    instr_t model_instr_s3;
    word_t  model_addr_s3;
    logic   model_valid_s3;
    word_t  model_cyc;
    word_t  model_ret;
    logic   model_clear;

    pc_sel_t  exp_pc_sel;
    wb_sel_t  exp_wb_sel;
    logic     exp_reg_we;
    mem_sel_t exp_mem_sel;
    word_t    exp_io_value;

    ctrl_top i_ctrl_top (
        .clk            (clk),
        .rst            (rst),
        .instruction_s2 (instruction_s2),
        .instr_valid_s2 (instr_valid_s2),
        .rs1_data       (rs1_data),
        .rs2_data       (rs2_data),
        .alu_addr       (alu_addr),
        .uart_rx_valid  (uart_rx_valid),
        .uart_tx_ready  (uart_tx_ready),
        .uart_rx_out    (uart_rx_out),
        .pc_sel         (pc_sel),
        .wb_sel         (wb_sel),
        .reg_we         (reg_we),
        .mem_sel        (mem_sel),
        .io_value       (io_value)
    );

    always #2 clk = ~clk;

    function automatic logic branch_holds(func3_t f3, word_t a, word_t b);
        logic holds;
        case (f3)
            FNC_BEQ:  holds = (a == b);
            FNC_BNE:  holds = (a != b);
            FNC_BLT:  holds = ($signed(a) < $signed(b));
            FNC_BGE:  holds = ($signed(a) >= $signed(b));
            FNC_BLTU: holds = (a < b);
            FNC_BGEU: holds = (a >= b);
            default:  holds = 1'b0;
        endcase
        return holds;
    endfunction

    function automatic pc_sel_t ref_pc_sel(logic reset, instr_t instr, word_t a, word_t b);
        opcode5_t op;
        op = instr[6:2];
        if (reset) begin
            return PC_RESET;
        end
        if (op == OPC_JAL_5 || op == OPC_JALR_5) begin
            return PC_ALU;
        end
        if (op == OPC_BRANCH_5 && branch_holds(instr[14:12], a, b)) begin
            return PC_ALU;
        end
        return PC_PLUS4;
    endfunction

    function automatic wb_sel_t ref_wb_sel(opcode5_t op);
        case (op)
            OPC_JAL_5, OPC_JALR_5:                 return WB_PC4;
            OPC_LOAD_5, OPC_BRANCH_5, OPC_STORE_5: return WB_MEM;
            default:                               return WB_ALU;
        endcase
    endfunction

    function automatic logic ref_reg_we(opcode5_t op);
        case (op)
            OPC_LUI_5, OPC_AUIPC_5, OPC_ARI_RTYPE_5, OPC_ARI_ITYPE_5: return 1'b1;
            OPC_JAL_5, OPC_JALR_5, OPC_LOAD_5:                        return 1'b1;
            default:                                                  return 1'b0;
        endcase
    endfunction

    function automatic mem_sel_t ref_mem_sel(word_t addr);
        case (addr[31:30])
            2'b01:   return MEM_BIOS;
            2'b10:   return MEM_IO;
            default: return MEM_DMEM;
        endcase
    endfunction

    function automatic logic is_counter_addr(word_t addr);
        return addr[4] || addr[5];
    endfunction

    function automatic word_t ref_io_value(word_t addr, logic rx_valid, logic tx_ready,
                                           logic [7:0] rx_byte, word_t cyc, word_t ret);
        if (is_counter_addr(addr)) begin
            return addr[2] ? ret : cyc;
        end
        if (addr[2]) begin
            return {24'd0, rx_byte};
        end
        return {30'd0, rx_valid, tx_ready};
    endfunction

    // control flow weighted toward branches plus one undecoded opcode
    function automatic opcode5_t pick_opcode(word_t r);
        int unsigned k;
        k = r % 13;
        case (k)
            0, 1, 2: return OPC_BRANCH_5;
            3:       return OPC_JAL_5;
            4:       return OPC_JALR_5;
            5:       return OPC_LUI_5;
            6:       return OPC_AUIPC_5;
            7:       return OPC_LOAD_5;
            8:       return OPC_STORE_5;
            9:       return OPC_ARI_RTYPE_5;
            10:      return OPC_ARI_ITYPE_5;
            11:      return OPC_CSR_5;
            default: return 5'b00011;
        endcase
    endfunction

    function automatic func3_t pick_branch_f3(word_t r);
        int unsigned k;
        k = r % 6;
        case (k)
            0:       return FNC_BEQ;
            1:       return FNC_BNE;
            2:       return FNC_BLT;
            3:       return FNC_BGE;
            4:       return FNC_BLTU;
            default: return FNC_BGEU;
        endcase
    endfunction

    // i/o offsets three times out of four and any address otherwise
    function automatic word_t pick_addr(word_t r_addr, word_t r_sel);
        int unsigned k;
        if (r_sel % 4 == 0) begin
            return r_addr;
        end
        k = r_addr % 5;
        case (k)
            0:       return IO_BASE;
            1:       return IO_BASE | 32'h04;
            2:       return CYC_ADDR;
            3:       return RET_ADDR;
            default: return IO_CNT_RST_ADDR;
        endcase
    endfunction

    task automatic report_mismatch(input string name, input word_t expected,
                                   input word_t actual);
        $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, expected, actual);
        $display("SIMULATION FAILED");
        $fatal(1, "mismatch on %s", name);
    endtask

    task automatic drive_random_cycle();
        word_t    r_sel;
        word_t    r_instr;
        word_t    r_addr;
        word_t    r_io;
        word_t    r_rs1;
        word_t    r_rs2;
        opcode5_t op;
        func3_t   f3;
        r_sel   = $random(seed);
        r_instr = $random(seed);
        r_addr  = $random(seed);
        r_io    = $random(seed);
        r_rs1   = $random(seed);
        r_rs2   = $random(seed);
        op = pick_opcode(r_sel);
        if (op == OPC_BRANCH_5) begin
            f3 = pick_branch_f3(r_sel >> 8);
        end else begin
            f3 = r_instr[14:12];
        end
        @(posedge clk);
        instruction_s2 <= {r_instr[31:15], f3, r_instr[11:7], op, 2'b11};
        instr_valid_s2 <= (r_sel[19:16] != 4'd0);
        rs1_data       <= r_rs1;
        // equal operands now and then so beq/bne both go each way
        rs2_data       <= (r_sel[23:20] == 4'd0) ? r_rs1 : r_rs2;
        alu_addr       <= pick_addr(r_addr, r_sel >> 24);
        uart_rx_valid  <= r_io[0];
        uart_tx_ready  <= r_io[1];
        uart_rx_out    <= r_io[15:8];
    endtask

    // store to the clear address then read one counter
    task automatic clear_and_read(input word_t read_addr);
        @(posedge clk);
        instruction_s2 <= STORE_WORD;
        instr_valid_s2 <= 1'b1;
        alu_addr       <= IO_CNT_RST_ADDR;
        @(posedge clk);
        instruction_s2 <= NOP_INSTR;
        instr_valid_s2 <= 1'b0;
        alu_addr       <= read_addr;
        repeat (RESUME_CYCLES) begin
            @(posedge clk);
            instr_valid_s2 <= 1'b1;
        end
    endtask

    always @(posedge clk) begin
        model_addr_s3 <= alu_addr;
        if (rst) begin
            model_instr_s3 <= NOP_INSTR;
            model_valid_s3 <= 1'b0;
        end else begin
            model_valid_s3 <= instr_valid_s2;
            model_instr_s3 <= instr_valid_s2 ? instruction_s2 : NOP_INSTR;
        end
    end

    assign model_clear = model_valid_s3 && (model_instr_s3[6:2] == OPC_STORE_5)
                         && (model_addr_s3 == IO_CNT_RST_ADDR);

    always @(posedge clk) begin
        if (rst || model_clear) begin
            model_cyc <= '0;
            model_ret <= '0;
        end else begin
            model_cyc <= model_cyc + 32'd1;
            if (model_valid_s3) begin
                model_ret <= model_ret + 32'd1;
            end
        end
    end

    always_comb begin
        exp_pc_sel   = ref_pc_sel(rst, instruction_s2, rs1_data, rs2_data);
        exp_wb_sel   = ref_wb_sel(model_instr_s3[6:2]);
        exp_reg_we   = ref_reg_we(model_instr_s3[6:2]);
        exp_mem_sel  = ref_mem_sel(model_addr_s3);
        exp_io_value = ref_io_value(model_addr_s3, uart_rx_valid, uart_tx_ready,
                                    uart_rx_out, model_cyc, model_ret);
    end

    a_reset_pc: assert property (@(posedge clk) rst |-> pc_sel == PC_RESET)
        else report_mismatch("pc_sel", 32'(PC_RESET), 32'($sampled(pc_sel)));

    a_pc_sel: assert property (@(posedge clk) !rst |-> pc_sel == exp_pc_sel)
        else report_mismatch("pc_sel", 32'($sampled(exp_pc_sel)), 32'($sampled(pc_sel)));

    a_wb_sel: assert property (@(posedge clk) !rst |-> wb_sel == exp_wb_sel)
        else report_mismatch("wb_sel", 32'($sampled(exp_wb_sel)), 32'($sampled(wb_sel)));

    a_reg_we: assert property (@(posedge clk) !rst |-> reg_we == exp_reg_we)
        else report_mismatch("reg_we", 32'($sampled(exp_reg_we)), 32'($sampled(reg_we)));

    a_mem_sel: assert property (@(posedge clk) !rst |-> mem_sel == exp_mem_sel)
        else report_mismatch("mem_sel", 32'($sampled(exp_mem_sel)), 32'($sampled(mem_sel)));

    a_io_value: assert property (@(posedge clk) !rst |-> io_value == exp_io_value)
        else report_mismatch("io_value", $sampled(exp_io_value), $sampled(io_value));

    // cycle count then retired count right after reset
    a_cyc_after_reset: assert property (@(posedge clk) $fell(rst) |-> io_value == 32'd0)
        else report_mismatch("io_value", 32'd0, $sampled(io_value));

    a_ret_after_reset: assert property (@(posedge clk) $fell(rst) |=> io_value == 32'd0)
        else report_mismatch("io_value", 32'd0, $sampled(io_value));

    a_clear_zero: assert property (@(posedge clk)
        (!rst && model_clear) |=> (!is_counter_addr(model_addr_s3) || io_value == 32'd0)
    ) else report_mismatch("io_value", 32'd0, $sampled(io_value));

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("SIMULATION FAILED");
            $fatal(1, "timeout");
        end
    end

    initial begin
        clk            = 1'b0;
        rst            = 1'b1;
        instruction_s2 = NOP_INSTR;
        instr_valid_s2 = 1'b0;
        rs1_data       = '0;
        rs2_data       = '0;
        alu_addr       = CYC_ADDR;
        uart_rx_valid  = 1'b0;
        uart_tx_ready  = 1'b0;
        uart_rx_out    = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst      <= 1'b0;
        // second cycle out of reset reads the retired count
        alu_addr <= RET_ADDR;
        repeat (RANDOM_CYCLES) drive_random_cycle();
        clear_and_read(CYC_ADDR);
        clear_and_read(RET_ADDR);
        repeat (DRAIN_CYCLES) @(posedge clk);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

/* build.f */
rtl/rv_ctrl_pkg.sv
rtl/branch_comp.sv
rtl/stage3_reg.sv
rtl/s3_control.sv
rtl/perf_counters.sv
rtl/ctrl_top.sv
test/tb_ctrl_top.sv

/* run_sim.sh */
#!/bin/sh
# build and run the ctrl_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_ctrl_top \
    --Mdir obj_dir -o sim_tb -f build.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "SIMULATION PASSED" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
